//--- design/mem_pkg.sv
package mem_pkg;

	// datapath widths
	localparam int xlen       = 64;
	localparam int ins_w      = 32;
	localparam int reg_addr_w = 5;

	// data RAM geometry, 64-bit words
	localparam int ram_words = 1024;
	localparam int ram_idx_w = $clog2(ram_words);  // 10

	localparam logic [xlen-1:0] ram_base = 64'h0000_0000_8000_0000;  // maps to word 0

	// major opcodes, ins[6:0]
	localparam logic [6:0] opc_load  = 7'b000_0011;
	localparam logic [6:0] opc_store = 7'b010_0011;

	// funct3, ins[14:12]; stores use f3_b .. f3_d only
	localparam logic [2:0] f3_b  = 3'b000;
	localparam logic [2:0] f3_h  = 3'b001;
	localparam logic [2:0] f3_w  = 3'b010;
	localparam logic [2:0] f3_d  = 3'b011;
	localparam logic [2:0] f3_bu = 3'b100;
	localparam logic [2:0] f3_hu = 3'b101;
	localparam logic [2:0] f3_wu = 3'b110;

endpackage

//--- design/store_align.sv
`timescale 1ns/1ps

module store_align
	import mem_pkg::*;
(
	input  logic [2:0]      funct3,
	input  logic [2:0]      byte_off,
	input  logic [xlen-1:0] rs2_data,
	output logic [7:0]      wmask,
	output logic [xlen-1:0] wdata,
	output logic            misaligned
);

	logic [7:0] size_mask;  // lanes written at offset 0
	logic [3:0] nbytes;
	logic       bad_f3;

	always_comb begin
		size_mask = 8'h00;
		nbytes    = 4'd0;
		bad_f3    = 1'b0;
		case (funct3)
			f3_b: begin
				size_mask = 8'b0000_0001;
				nbytes    = 4'd1;
			end
			f3_h: begin
				size_mask = 8'b0000_0011;
				nbytes    = 4'd2;
			end
			f3_w: begin
				size_mask = 8'b0000_1111;
				nbytes    = 4'd4;
			end
			f3_d: begin
				size_mask = 8'b1111_1111;
				nbytes    = 4'd8;
			end
			default: bad_f3 = 1'b1;  // no such store size
		endcase
	end

	// last byte must stay inside the aligned word
	assign misaligned = bad_f3 || (({1'b0, byte_off} + nbytes) > 4'd8);

	assign wmask = misaligned ? 8'h00 : (size_mask << byte_off);
	assign wdata = rs2_data << {byte_off, 3'b000};  // move into byte lanes

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps

module load_align
	import mem_pkg::*;
(
	input  logic [2:0]      funct3,
	input  logic [2:0]      byte_off,
	input  logic [xlen-1:0] rdata,
	output logic [xlen-1:0] load_data,
	output logic            misaligned
);

	logic [xlen-1:0] lane;  // addressed bytes down at bit 0
	logic [xlen-1:0] ext_data;
	logic [3:0]      nbytes;
	logic            bad_f3;

	assign lane = rdata >> {byte_off, 3'b000};

	always_comb begin
		ext_data = '0;
		nbytes   = 4'd0;
		bad_f3   = 1'b0;
		case (funct3)
			f3_b: begin
				nbytes   = 4'd1;
				ext_data = {{(xlen-8){lane[7]}}, lane[7:0]};
			end
			f3_h: begin
				nbytes   = 4'd2;
				ext_data = {{(xlen-16){lane[15]}}, lane[15:0]};
			end
			f3_w: begin
				nbytes   = 4'd4;
				ext_data = {{(xlen-32){lane[31]}}, lane[31:0]};
			end
			f3_d: begin
				nbytes   = 4'd8;
				ext_data = rdata;  // whole word
			end
			f3_bu: begin
				nbytes   = 4'd1;
				ext_data = {{(xlen-8){1'b0}}, lane[7:0]};
			end
			f3_hu: begin
				nbytes   = 4'd2;
				ext_data = {{(xlen-16){1'b0}}, lane[15:0]};
			end
			f3_wu: begin
				nbytes   = 4'd4;
				ext_data = {{(xlen-32){1'b0}}, lane[31:0]};
			end
			default: bad_f3 = 1'b1;
		endcase
	end

	// same crossing rule as the store side
	assign misaligned = bad_f3 || (({1'b0, byte_off} + nbytes) > 4'd8);

	assign load_data = misaligned ? '0 : ext_data;

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram
	import mem_pkg::*;
(
	input  logic                 clk,
	input  logic                 we,
	input  logic [ram_idx_w-1:0] widx,
	input  logic [7:0]           wmask,
	input  logic [xlen-1:0]      wdata,
	input  logic [ram_idx_w-1:0] ridx,
	output logic [xlen-1:0]      rdata
);

	logic [xlen-1:0] mem [ram_words];

	assign rdata = mem[ridx];  // async read

	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask[b]) begin
					mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// the stage must never issue a write for a misaligned or unknown store
	a_no_empty_write: assert property (
		@(posedge clk) we |-> (wmask != 8'h00)
	) else $error("data_ram write with empty byte mask");

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
	import mem_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [xlen-1:0]       in_pc,
	input  logic [ins_w-1:0]      in_ins,
	input  logic [xlen-1:0]       in_alu_result,
	input  logic [xlen-1:0]       in_rs2_data,
	input  logic [reg_addr_w-1:0] in_rd,
	input  logic                  in_reg_w_en,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [xlen-1:0]       out_pc,
	output logic [ins_w-1:0]      out_ins,
	output logic [reg_addr_w-1:0] out_rd,
	output logic                  out_reg_w_en,
	output logic [xlen-1:0]       out_wb_data,
	output logic                  out_misaligned,
	output logic                  fwd_reg_w_en,
	output logic [reg_addr_w-1:0] fwd_rd,
	output logic [xlen-1:0]       fwd_wb_data
);

	logic [2:0]           funct3;
	logic                 is_load;
	logic                 is_store;
	logic [ram_idx_w+2:0] ram_off;  // byte offset into RAM, wraps
	logic [ram_idx_w-1:0] word_idx;
	logic [2:0]           byte_off;
	logic                 accept;
	logic [7:0]           st_mask;
	logic [xlen-1:0]      st_data;
	logic                 st_mis;
	logic [xlen-1:0]      ram_rdata;
	logic [xlen-1:0]      ld_data;
	logic                 ld_mis;
	logic                 ram_we;
	logic                 wb_misaligned;
	logic                 wb_reg_w_en;
	logic [xlen-1:0]      wb_data;

	assign funct3   = in_ins[14:12];
	assign is_load  = (in_ins[6:0] == opc_load);
	assign is_store = (in_ins[6:0] == opc_store);

	assign ram_off  = in_alu_result[ram_idx_w+2:0] - ram_base[ram_idx_w+2:0];
	assign word_idx = ram_off[ram_idx_w+2:3];
	assign byte_off = ram_off[2:0];

	assign in_ready = out_ready || !out_valid;  // room once the held item leaves
	assign accept   = in_valid && in_ready;

	store_align u_store_align (
		.funct3     (funct3),
		.byte_off   (byte_off),
		.rs2_data   (in_rs2_data),
		.wmask      (st_mask),
		.wdata      (st_data),
		.misaligned (st_mis)
	);

	assign ram_we = accept && is_store && !st_mis;

	data_ram u_data_ram (
		.clk   (clk),
		.we    (ram_we),
		.widx  (word_idx),
		.wmask (st_mask),
		.wdata (st_data),
		.ridx  (word_idx),
		.rdata (ram_rdata)
	);

	load_align u_load_align (
		.funct3     (funct3),
		.byte_off   (byte_off),
		.rdata      (ram_rdata),
		.load_data  (ld_data),
		.misaligned (ld_mis)
	);

	assign wb_misaligned = (is_load && ld_mis) || (is_store && st_mis);
	assign wb_reg_w_en   = in_reg_w_en && !is_store && !(is_load && ld_mis);

	always_comb begin
		if (is_load)
			wb_data = ld_data;  // already zero when misaligned
		else if (is_store)
			wb_data = '0;
		else
			wb_data = in_alu_result;
	end

	// bypass toward execute
	assign fwd_reg_w_en = wb_reg_w_en;
	assign fwd_rd       = in_rd;
	assign fwd_wb_data  = wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			out_reg_w_en <= 1'b0;
		end else if (in_ready) begin
			out_valid    <= in_valid;
			out_reg_w_en <= in_valid && wb_reg_w_en;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc         <= in_pc;
			out_ins        <= in_ins;
			out_rd         <= in_rd;
			out_wb_data    <= wb_data;
			out_misaligned <= wb_misaligned;
		end
	end

	// execute side must hold its item until taken
	a_in_stable: assert property (
		@(posedge clk) disable iff (reset)
		in_valid && !in_ready |=> in_valid &&
			$stable({in_pc, in_ins, in_alu_result, in_rs2_data, in_rd, in_reg_w_en})
	) else $error("mem_stage input changed under back-pressure");

	a_reset_empty: assert property (
		@(posedge clk) reset |=> !out_valid
	) else $error("mem_stage out_valid high after reset");

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
	import mem_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [xlen-1:0]       wdata,
	input  logic [reg_addr_w-1:0] raddr_a,
	output logic [xlen-1:0]       rdata_a,
	input  logic [reg_addr_w-1:0] raddr_b,
	output logic [xlen-1:0]       rdata_b
);

	logic [xlen-1:0] regs [1:2**reg_addr_w-1];  // no storage for x0

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	// a writeback aimed at x0 must not become visible
	a_x0_zero: assert property (
		@(posedge clk) disable iff (reset)
		we && (waddr == '0) |=> ((raddr_a != '0) || (rdata_a == '0)) &&
			((raddr_b != '0) || (rdata_b == '0))
	) else $error("x0 read back nonzero after write");

endmodule

//--- design/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
	import mem_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [xlen-1:0]       in_pc,
	input  logic [ins_w-1:0]      in_ins,
	input  logic [xlen-1:0]       in_alu_result,
	input  logic [xlen-1:0]       in_rs2_data,
	input  logic [reg_addr_w-1:0] in_rd,
	input  logic                  in_reg_w_en,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [xlen-1:0]       out_pc,
	output logic [ins_w-1:0]      out_ins,
	output logic [reg_addr_w-1:0] out_rd,
	output logic                  out_reg_w_en,
	output logic [xlen-1:0]       out_wb_data,
	output logic                  out_misaligned,
	output logic                  fwd_reg_w_en,
	output logic [reg_addr_w-1:0] fwd_rd,
	output logic [xlen-1:0]       fwd_wb_data,
	input  logic [reg_addr_w-1:0] rf_raddr_a,
	output logic [xlen-1:0]       rf_rdata_a,
	input  logic [reg_addr_w-1:0] rf_raddr_b,
	output logic [xlen-1:0]       rf_rdata_b
);

	logic rf_we;

	mem_stage u_mem_stage (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_pc          (in_pc),
		.in_ins         (in_ins),
		.in_alu_result  (in_alu_result),
		.in_rs2_data    (in_rs2_data),
		.in_rd          (in_rd),
		.in_reg_w_en    (in_reg_w_en),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_pc         (out_pc),
		.out_ins        (out_ins),
		.out_rd         (out_rd),
		.out_reg_w_en   (out_reg_w_en),
		.out_wb_data    (out_wb_data),
		.out_misaligned (out_misaligned),
		.fwd_reg_w_en   (fwd_reg_w_en),
		.fwd_rd         (fwd_rd),
		.fwd_wb_data    (fwd_wb_data)
	);

	assign rf_we = out_valid && out_ready && out_reg_w_en;  // write on the out transfer

	reg_file u_reg_file (
		.clk     (clk),
		.reset   (reset),
		.we      (rf_we),
		.waddr   (out_rd),
		.wdata   (out_wb_data),
		.raddr_a (rf_raddr_a),
		.rdata_a (rf_rdata_a),
		.raddr_b (rf_raddr_b),
		.rdata_b (rf_rdata_b)
	);

endmodule

//--- include/mem_test_table.svh
`ifndef mem_test_table_svh
`define mem_test_table_svh

typedef struct packed {
	logic [ins_w-1:0]      ins;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       rs2_data;
	logic [reg_addr_w-1:0] rd;
	logic                  reg_w_en;
	logic [xlen-1:0]       exp_wb_data;
	logic                  exp_misaligned;
	logic                  exp_reg_w;
} tbl_row_t;

localparam int tbl_rows = 30;

localparam tbl_row_t tbl [tbl_rows] = '{
	'{32'h0020_B023, 64'h8000_0100, 64'h8877_1122_F0E1_7F80, 5'd5, 1'b1, 64'h0, 1'b0, 1'b0},
	'{32'h0000_8503, 64'h8000_0100, 64'h0, 5'd10, 1'b1, 64'hFFFF_FFFF_FFFF_FF80, 1'b0, 1'b1},
	'{32'h0000_C583, 64'h8000_0101, 64'h0, 5'd11, 1'b1, 64'h0000_0000_0000_007F, 1'b0, 1'b1},
	'{32'h0000_8603, 64'h8000_0102, 64'h0, 5'd12, 1'b1, 64'hFFFF_FFFF_FFFF_FFE1, 1'b0, 1'b1},
	'{32'h0000_C683, 64'h8000_0107, 64'h0, 5'd13, 1'b1, 64'h0000_0000_0000_0088, 1'b0, 1'b1},
	'{32'h0000_9703, 64'h8000_0102, 64'h0, 5'd14, 1'b1, 64'hFFFF_FFFF_FFFF_F0E1, 1'b0, 1'b1},
	'{32'h0000_D783, 64'h8000_0106, 64'h0, 5'd15, 1'b1, 64'h0000_0000_0000_8877, 1'b0, 1'b1},
	'{32'h0000_9803, 64'h8000_0100, 64'h0, 5'd16, 1'b1, 64'h0000_0000_0000_7F80, 1'b0, 1'b1},
	'{32'h0000_9F03, 64'h8000_0101, 64'h0, 5'd30, 1'b1, 64'hFFFF_FFFF_FFFF_E17F, 1'b0, 1'b1},
	'{32'h0000_A883, 64'h8000_0100, 64'h0, 5'd17, 1'b1, 64'hFFFF_FFFF_F0E1_7F80, 1'b0, 1'b1},
	'{32'h0000_E903, 64'h8000_0104, 64'h0, 5'd18, 1'b1, 64'h0000_0000_8877_1122, 1'b0, 1'b1},
	'{32'h0000_A983, 64'h8000_0104, 64'h0, 5'd19, 1'b1, 64'hFFFF_FFFF_8877_1122, 1'b0, 1'b1},
	'{32'h0000_BA03, 64'h8000_0100, 64'h0, 5'd20, 1'b1, 64'h8877_1122_F0E1_7F80, 1'b0, 1'b1},
	'{32'h0020_8023, 64'h8000_0103, 64'h1234_5678_9ABC_DE55, 5'd0, 1'b0, 64'h0, 1'b0, 1'b0},
	'{32'h0020_9023, 64'h8000_0106, 64'hAAAA_AAAA_AAAA_BEEF, 5'd0, 1'b0, 64'h0, 1'b0, 1'b0},
	'{32'h0000_BA83, 64'h8000_0100, 64'h0, 5'd21, 1'b1, 64'hBEEF_1122_55E1_7F80, 1'b0, 1'b1},
	'{32'h0000_8B13, 64'hDEAD_BEEF, 64'h0, 5'd22, 1'b1, 64'h0000_0000_DEAD_BEEF, 1'b0, 1'b1},
	'{32'h0000_8013, 64'h1234, 64'h0, 5'd0, 1'b1, 64'h0000_0000_0000_1234, 1'b0, 1'b1},
	'{32'h0000_8B93, 64'h5A5A, 64'h0, 5'd23, 1'b0, 64'h0000_0000_0000_5A5A, 1'b0, 1'b0},
	'{32'h0000_BC03, 64'h8000_0104, 64'h0, 5'd24, 1'b1, 64'h0, 1'b1, 1'b0},  // ld +4
	'{32'h0000_9C83, 64'h8000_0107, 64'h0, 5'd25, 1'b1, 64'h0, 1'b1, 1'b0},  // lh +7
	'{32'h0000_AD03, 64'h8000_0105, 64'h0, 5'd26, 1'b1, 64'h0, 1'b1, 1'b0},  // lw +5
	'{32'h0020_B023, 64'h8000_0104, 64'hFFFF_FFFF_FFFF_FFFF, 5'd0, 1'b0, 64'h0, 1'b1, 1'b0},
	'{32'h0020_A023, 64'h8000_0106, 64'h0BAD_0BAD_0BAD_0BAD, 5'd0, 1'b0, 64'h0, 1'b1, 1'b0},
	'{32'h0020_9023, 64'h8000_0107, 64'h0000_0000_0000_DEAD, 5'd0, 1'b0, 64'h0, 1'b1, 1'b0},
	'{32'h0000_BD83, 64'h8000_0100, 64'h0, 5'd27, 1'b1, 64'hBEEF_1122_55E1_7F80, 1'b0, 1'b1},
	'{32'h0020_A023, 64'h8000_0208, 64'h0000_0000_CAFE_F00D, 5'd0, 1'b0, 64'h0, 1'b0, 1'b0},
	'{32'h0000_EE03, 64'h8000_0208, 64'h0, 5'd28, 1'b1, 64'h0000_0000_CAFE_F00D, 1'b0, 1'b1},
	'{32'h0000_AE83, 64'h8000_0208, 64'h0, 5'd29, 1'b1, 64'hFFFF_FFFF_CAFE_F00D, 1'b0, 1'b1},
	'{32'h0000_8B13, 64'h0F0F, 64'h0, 5'd22, 1'b1, 64'h0000_0000_0000_0F0F, 1'b0, 1'b1}
};

`endif

//--- verif/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
	import mem_pkg::*;
;

`include "mem_test_table.svh"

	localparam int reset_cycles = 4;
	localparam int wd_cycles    = tbl_rows * 40 + reset_cycles;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	logic [xlen-1:0]       in_pc;
	logic [ins_w-1:0]      in_ins;
	logic [xlen-1:0]       in_alu_result;
	logic [xlen-1:0]       in_rs2_data;
	logic [reg_addr_w-1:0] in_rd;
	logic                  in_reg_w_en;
	logic                  out_valid;
	logic                  out_ready;
	logic [xlen-1:0]       out_pc;
	logic [ins_w-1:0]      out_ins;
	logic [reg_addr_w-1:0] out_rd;
	logic                  out_reg_w_en;
	logic [xlen-1:0]       out_wb_data;
	logic                  out_misaligned;
	logic                  fwd_reg_w_en;
	logic [reg_addr_w-1:0] fwd_rd;
	logic [xlen-1:0]       fwd_wb_data;
	logic [reg_addr_w-1:0] rf_raddr_a;
	logic [xlen-1:0]       rf_rdata_a;
	logic [reg_addr_w-1:0] rf_raddr_b;
	logic [xlen-1:0]       rf_rdata_b;

	int              errors;
	int              checks;
	int              out_idx;
	logic [15:0]     lfsr;
	logic [xlen-1:0] shadow [32];  // expected register contents
	logic            model_full;  // output register occupancy

	// payload seen while the consumer stalls
	logic            stall_pending;
	logic [xlen-1:0] held_pc;
	logic [xlen-1:0] held_wb;
	logic [ins_w-1:0] held_ins;
	logic [reg_addr_w-1:0] held_rd;
	logic            held_mis;
	logic            held_wen;

	mem_subsystem u_mem_subsystem (.*);

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	function automatic logic [xlen-1:0] row_pc(input int i);
		return 64'h0000_0000_0001_0000 + 64'(i) * 4;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// random back-pressure from one lfsr bit per cycle
	always @(posedge clk) begin
		lfsr = lfsr_step(lfsr);
		out_ready <= lfsr[0];
	end

	always @(posedge clk) begin
		if (!reset) begin
			// handshake model driven only by in_valid and out_ready
			check("out_valid", out_valid, model_full);
			check("in_ready", in_ready, out_ready || !model_full);
			if (out_ready || !model_full)
				model_full = in_valid;
			if (stall_pending) begin
				check("out_valid held", out_valid, 1'b1);
				check("out_pc held", out_pc, held_pc);
				check("out_ins held", out_ins, held_ins);
				check("out_rd held", out_rd, held_rd);
				check("out_wb_data held", out_wb_data, held_wb);
				check("out_misaligned held", out_misaligned, held_mis);
				check("out_reg_w_en held", out_reg_w_en, held_wen);
			end
			stall_pending = out_valid && !out_ready;
			if (stall_pending) begin
				held_pc  = out_pc;
				held_ins = out_ins;
				held_rd  = out_rd;
				held_wb  = out_wb_data;
				held_mis = out_misaligned;
				held_wen = out_reg_w_en;
			end
			if (out_valid && out_ready) begin
				if (out_idx >= tbl_rows) begin
					errors++;
					$display("output transfer seen after the last table row was taken");
				end else begin
					check($sformatf("out_pc row %0d", out_idx), out_pc, row_pc(out_idx));
					check($sformatf("out_ins row %0d", out_idx), out_ins, tbl[out_idx].ins);
					check($sformatf("out_rd row %0d", out_idx), out_rd, tbl[out_idx].rd);
					check($sformatf("out_wb_data row %0d", out_idx), out_wb_data,
						tbl[out_idx].exp_wb_data);
					check($sformatf("out_misaligned row %0d", out_idx), out_misaligned,
						tbl[out_idx].exp_misaligned);
					check($sformatf("out_reg_w_en row %0d", out_idx), out_reg_w_en,
						tbl[out_idx].exp_reg_w);
					out_idx++;
				end
			end
		end
	end

	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: outputs stalled with %0d of %0d rows received, errors %0d",
			out_idx, tbl_rows, errors);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		errors        = 0;
		checks        = 0;
		out_idx       = 0;
		stall_pending = 1'b0;
		model_full    = 1'b0;
		lfsr          = 16'd37162;
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_pc         = '0;
		in_ins        = '0;
		in_alu_result = '0;
		in_rs2_data   = '0;
		in_rd         = '0;
		in_reg_w_en   = 1'b0;
		out_ready     = 1'b0;
		rf_raddr_a    = '0;
		rf_raddr_b    = '0;
		for (int r = 0; r < 32; r++)
			shadow[r] = '0;
		for (int i = 0; i < tbl_rows; i++) begin
			if (tbl[i].exp_reg_w && tbl[i].rd != 0)
				shadow[tbl[i].rd] = tbl[i].exp_wb_data;
		end

		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < tbl_rows; i++) begin
			in_valid      <= 1'b1;
			in_pc         <= row_pc(i);
			in_ins        <= tbl[i].ins;
			in_alu_result <= tbl[i].alu_result;
			in_rs2_data   <= tbl[i].rs2_data;
			in_rd         <= tbl[i].rd;
			in_reg_w_en   <= tbl[i].reg_w_en;
			@(posedge clk);
			while (!in_ready)
				@(posedge clk);
			// bypass values at the acceptance edge
			check($sformatf("fwd_wb_data row %0d", i), fwd_wb_data, tbl[i].exp_wb_data);
			check($sformatf("fwd_reg_w_en row %0d", i), fwd_reg_w_en, tbl[i].exp_reg_w);
			check($sformatf("fwd_rd row %0d", i), fwd_rd, tbl[i].rd);
		end
		in_valid <= 1'b0;

		wait (out_idx == tbl_rows);
		repeat (4) @(posedge clk);  // catch duplicates

		for (int r = 0; r < 32; r += 2) begin
			rf_raddr_a <= 5'(r);
			rf_raddr_b <= 5'(r + 1);
			@(posedge clk);
			check($sformatf("rf_rdata_a x%0d", r), rf_rdata_a, shadow[r]);
			check($sformatf("rf_rdata_b x%0d", r + 1), rf_rdata_b, shadow[r + 1]);
		end

		$display("checks %0d errors %0d rows %0d", checks, errors, out_idx);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- mem_subsystem.f
+incdir+include
design/mem_pkg.sv
design/store_align.sv
design/load_align.sv
design/data_ram.sv
design/mem_stage.sv
design/reg_file.sv
design/mem_subsystem.sv
verif/mem_subsystem_tb.sv
